/* mips_pipe.f */
+incdir+include
source/mips_pkg.sv
source/instr_fetch.sv
source/decode_stage.sv
source/hazard_forward.sv
source/execute_mem.sv
source/mips_top.sv
test/mips_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mips_pipe testbench with Verilator
verilator --binary --timing --top-module mips_tb -f mips_pipe.f -o mips_sim || exit 1
./obj_dir/mips_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1 || grep -q "Test passed" sim.log

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           run,
    input  wire [data_width-1:0]          if_id_instr,
    input  wire [data_width-1:0]          if_id_pc,
    input  wire                           if_id_valid,
    input  wire                           stall,
    input  wire mem_wb_t                  mem_wb,
    output logic [reg_addr_width-1:0]     id_rs,
    output logic [reg_addr_width-1:0]     id_rt,
    output logic                          id_uses_rt,
    output logic                          id_is_branch,
    output logic                          branch_taken,
    output logic [data_width-1:0]         branch_target,
    output id_ex_t                        id_ex
);

    localparam int num_regs = 1 << reg_addr_width;

    instr_t                    instr;
    logic [data_width-1:0]     regs [num_regs];
    logic [data_width-1:0]     rs_val;
    logic [data_width-1:0]     rt_val;
    logic [data_width-1:0]     imm_sext;
    logic [data_width-1:0]     imm_zext;
    logic [data_width-1:0]     pc_next;
    logic                      wb_write;
    alu_op_t                   alu_op;
    logic [reg_addr_width-1:0] dest;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      b_imm;
    logic                      zext;
    logic                      uses_rt;
    logic                      is_shift;
    logic                      is_jump;
    logic                      is_beq;
    logic                      is_bne;
    id_ex_t                    id_ex_next;

    assign instr = instr_t'(if_id_instr);
    assign wb_write = mem_wb.valid && mem_wb.reg_write && mem_wb.dest != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[mem_wb.dest] <= mem_wb.result;
        end
    end

    // same-cycle writeback goes straight to the read
    assign rs_val = (instr.rs == '0) ? '0 :
                    (wb_write && mem_wb.dest == instr.rs) ? mem_wb.result : regs[instr.rs];
    assign rt_val = (instr.rt == '0) ? '0 :
                    (wb_write && mem_wb.dest == instr.rt) ? mem_wb.result : regs[instr.rt];

    assign imm_sext = {{(data_width-16){if_id_instr[15]}}, if_id_instr[15:0]};
    assign imm_zext = {{(data_width-16){1'b0}}, if_id_instr[15:0]};
    assign pc_next = if_id_pc + data_width'(4);

    always_comb begin
        alu_op = alu_add;
        dest = instr.rt;
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        b_imm = 1'b1;
        zext = 1'b0;
        uses_rt = 1'b0;
        is_shift = 1'b0;
        is_jump = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (instr.opcode)
            op_special: begin
                dest = instr.rd;
                b_imm = 1'b0;
                uses_rt = 1'b1;
                reg_write = 1'b1;
                case (instr.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        alu_op = alu_sll;
                        is_shift = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu: reg_write = 1'b1;
            op_andi: begin
                alu_op = alu_and;
                zext = 1'b1;
                reg_write = 1'b1;
            end
            op_ori: begin
                alu_op = alu_or;
                zext = 1'b1;
                reg_write = 1'b1;
            end
            op_lw: begin
                reg_write = 1'b1;
                mem_read = 1'b1;
            end
            op_sw: begin
                mem_write = 1'b1;
                uses_rt = 1'b1;
            end
            op_beq: begin
                is_beq = 1'b1;
                uses_rt = 1'b1;
            end
            op_bne: begin
                is_bne = 1'b1;
                uses_rt = 1'b1;
            end
            op_j: is_jump = 1'b1;
            default: ;
        endcase
    end

    // j and sll carry no rs operand
    assign id_rs = (if_id_valid && !is_jump && !is_shift) ? instr.rs : '0;
    assign id_rt = instr.rt;
    assign id_uses_rt = if_id_valid && uses_rt;
    assign id_is_branch = if_id_valid && (is_beq || is_bne);

    assign branch_taken = if_id_valid && run && !stall &&
                          (is_jump || (is_beq && rs_val == rt_val) ||
                           (is_bne && rs_val != rt_val));
    assign branch_target = is_jump ? {pc_next[31:28], if_id_instr[25:0], 2'b00} :
                                     pc_next + {imm_sext[data_width-3:0], 2'b00};

    always_comb begin
        id_ex_next.alu_op = alu_op;
        // shift amount rides in operand a
        id_ex_next.a = is_shift ? {{(data_width-5){1'b0}}, instr.shamt} : rs_val;
        id_ex_next.b = !b_imm ? rt_val : (zext ? imm_zext : imm_sext);
        id_ex_next.store_data = rt_val;
        id_ex_next.rs = is_shift ? '0 : instr.rs;
        id_ex_next.rt = instr.rt;
        id_ex_next.dest = dest;
        id_ex_next.b_imm = b_imm;
        id_ex_next.reg_write = reg_write;
        id_ex_next.mem_read = mem_read;
        id_ex_next.mem_write = mem_write;
        id_ex_next.valid = if_id_valid;
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_next;
        // bubble on stall
        if (reset || !run || stall) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/execute_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_mem import mips_pkg::*; #(
    parameter int dmem_depth = 1024
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 run,
    input  wire                 load_valid,
    input  wire load_req_t      load,
    input  wire id_ex_t         id_ex,
    input  wire fwd_sel_t       fwd_a,
    input  wire fwd_sel_t       fwd_b,
    output ex_mem_t             ex_mem,
    output mem_wb_t             mem_wb,
    output logic                store_valid,
    output store_t              store
);

    localparam int dmem_aw = $clog2(dmem_depth);

    logic [data_width-1:0] dmem [dmem_depth];
    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] st_data;
    logic [data_width-1:0] alu_result;
    logic [dmem_aw-1:0]    mem_index;
    logic                  sw_write;

    function automatic logic [data_width-1:0] forward(
        input fwd_sel_t              sel,
        input logic [data_width-1:0] reg_val,
        input logic [data_width-1:0] mem_val,
        input logic [data_width-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = forward(fwd_a, id_ex.a, ex_mem.result, mem_wb.result);
    assign op_b = id_ex.b_imm ? id_ex.b : forward(fwd_b, id_ex.b, ex_mem.result, mem_wb.result);
    assign st_data = forward(fwd_b, id_ex.store_data, ex_mem.result, mem_wb.result);

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_slt: alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll: alu_result = op_b << op_a[4:0];
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem.result <= alu_result;
        ex_mem.store_data <= st_data;
        ex_mem.dest <= id_ex.dest;
        ex_mem.reg_write <= id_ex.reg_write;
        ex_mem.mem_read <= id_ex.mem_read;
        ex_mem.mem_write <= id_ex.mem_write;
        if (reset || !run) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    assign mem_index = ex_mem.result[dmem_aw+1:2];
    assign sw_write = run && ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge clk) begin
        if (!run) begin
            if (load_valid && load.target == target_dmem) begin
                dmem[load.addr[dmem_aw-1:0]] <= load.data;
            end
        end else if (sw_write) begin
            dmem[mem_index] <= ex_mem.store_data;
        end
    end

    // monitor copy of every sw write
    assign store_valid = sw_write;
    assign store = '{addr: ex_mem.result[mem_addr_width+1:2], data: ex_mem.store_data};

    // load data is read one edge after the address
    always_ff @(posedge clk) begin
        mem_wb.result <= ex_mem.mem_read ? dmem[mem_index] : ex_mem.result;
        mem_wb.dest <= ex_mem.dest;
        mem_wb.reg_write <= ex_mem.reg_write;
        if (reset || !run) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
        end
    end

endmodule

`default_nettype wire

/* source/hazard_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_forward import mips_pkg::*; (
    input  wire [reg_addr_width-1:0] id_rs,
    input  wire [reg_addr_width-1:0] id_rt,
    input  wire                      id_uses_rt,
    input  wire                      id_is_branch,
    input  wire id_ex_t              id_ex,
    input  wire ex_mem_t             ex_mem,
    input  wire mem_wb_t             mem_wb,
    output logic                     stall,
    output fwd_sel_t                 fwd_a,
    output fwd_sel_t                 fwd_b
);

    logic ex_writes;
    logic mem_writes;
    logic wb_writes;
    logic ex_hit;
    logic mem_hit;

    // memory stage holds the younger value and wins
    function automatic fwd_sel_t pick_source(
        input logic [reg_addr_width-1:0] src,
        input logic                      mem_w,
        input logic [reg_addr_width-1:0] mem_dest,
        input logic                      wb_w,
        input logic [reg_addr_width-1:0] wb_dest
    );
        if (mem_w && mem_dest == src) begin
            return fwd_mem;
        end
        if (wb_w && wb_dest == src) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    assign ex_writes = id_ex.valid && id_ex.reg_write && id_ex.dest != '0;
    assign mem_writes = ex_mem.valid && ex_mem.reg_write && ex_mem.dest != '0;
    assign wb_writes = mem_wb.valid && mem_wb.reg_write && mem_wb.dest != '0;

    assign ex_hit = ex_writes && (id_ex.dest == id_rs || (id_uses_rt && id_ex.dest == id_rt));
    assign mem_hit = mem_writes &&
                     (ex_mem.dest == id_rs || (id_uses_rt && ex_mem.dest == id_rt));

    // load-use or a branch compare waiting on a result still in flight
    assign stall = (ex_hit && id_ex.mem_read) || (id_is_branch && (ex_hit || mem_hit));

    assign fwd_a = pick_source(id_ex.rs, mem_writes, ex_mem.dest, wb_writes, mem_wb.dest);
    assign fwd_b = pick_source(id_ex.rt, mem_writes, ex_mem.dest, wb_writes, mem_wb.dest);

endmodule

`default_nettype wire

/* source/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import mips_pkg::*; #(
    parameter int imem_depth = 1024
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        run,
    input  wire                        load_valid,
    input  wire load_req_t             load,
    input  wire                        stall,
    input  wire                        branch_taken,
    input  wire [data_width-1:0]       branch_target,
    output logic [data_width-1:0]      if_id_instr,
    output logic [data_width-1:0]      if_id_pc,
    output logic                       if_id_valid
);

    localparam int imem_aw = $clog2(imem_depth);

    logic [data_width-1:0] imem [imem_depth];
    logic [data_width-1:0] pc;

    always_ff @(posedge clk) begin
        if (!run && load_valid && load.target == target_imem) begin
            imem[load.addr[imem_aw-1:0]] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pc <= '0;
            if_id_valid <= 1'b0;
        end else if (branch_taken) begin
            // redirect and drop the word fetched behind the branch
            pc <= branch_target;
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            pc <= pc + data_width'(4);
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_instr <= imem[pc[imem_aw+1:2]];
            if_id_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    // word address width of the largest memory
    localparam int mem_addr_width = 10;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } func_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef enum logic {
        target_imem,
        target_dmem
    } mem_target_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] rd;
        logic [4:0]                shamt;
        func_t                     funct;
    } instr_t;

    typedef struct packed {
        mem_target_t               target;
        logic [mem_addr_width-1:0] addr;
        logic [data_width-1:0]     data;
    } load_req_t;

    typedef struct packed {
        logic [mem_addr_width-1:0] addr;
        logic [data_width-1:0]     data;
    } store_t;

    typedef struct packed {
        alu_op_t                   alu_op;
        logic [data_width-1:0]     a;
        logic [data_width-1:0]     b;
        logic [data_width-1:0]     store_data;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] dest;
        // operand b holds an immediate
        logic                      b_imm;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      valid;
    } id_ex_t;

    typedef struct packed {
        logic [data_width-1:0]     result;
        logic [data_width-1:0]     store_data;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      valid;
    } ex_mem_t;

    typedef struct packed {
        logic [data_width-1:0]     result;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic                      valid;
    } mem_wb_t;

endpackage

`default_nettype wire

/* source/mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top import mips_pkg::*; #(
    parameter int imem_depth = 1024,
    parameter int dmem_depth = 1024
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            run,
    input  wire            load_valid,
    input  wire load_req_t load,
    output logic           load_ready,
    output logic           store_valid,
    output store_t         store
);

    logic [data_width-1:0]     if_id_instr;
    logic [data_width-1:0]     if_id_pc;
    logic                      if_id_valid;
    logic [reg_addr_width-1:0] id_rs;
    logic [reg_addr_width-1:0] id_rt;
    logic                      id_uses_rt;
    logic                      id_is_branch;
    logic                      branch_taken;
    logic [data_width-1:0]     branch_target;
    logic                      stall;
    fwd_sel_t                  fwd_a;
    fwd_sel_t                  fwd_b;
    id_ex_t                    id_ex;
    ex_mem_t                   ex_mem;
    mem_wb_t                   mem_wb;

    // loader owns the memories while the core is held
    assign load_ready = !run;

    instr_fetch #(
        .imem_depth (imem_depth)
    ) i_instr_fetch (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .load_valid    (load_valid),
        .load          (load),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .if_id_instr   (if_id_instr),
        .if_id_pc      (if_id_pc),
        .if_id_valid   (if_id_valid)
    );

    decode_stage i_decode_stage (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .if_id_instr   (if_id_instr),
        .if_id_pc      (if_id_pc),
        .if_id_valid   (if_id_valid),
        .stall         (stall),
        .mem_wb        (mem_wb),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_uses_rt    (id_uses_rt),
        .id_is_branch  (id_is_branch),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (id_ex)
    );

    hazard_forward i_hazard_forward (
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .id_uses_rt   (id_uses_rt),
        .id_is_branch (id_is_branch),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .stall        (stall),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

    execute_mem #(
        .dmem_depth (dmem_depth)
    ) i_execute_mem (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .load_valid  (load_valid),
        .load        (load),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .store_valid (store_valid),
        .store       (store)
    );

endmodule

`default_nettype wire

/* include/mips_ref_model.svh */
`ifndef mips_ref_model_svh
`define mips_ref_model_svh

// MIPS primary opcodes and R-type function codes
localparam logic [5:0] opc_special = 6'h00;
localparam logic [5:0] opc_j       = 6'h02;
localparam logic [5:0] opc_beq     = 6'h04;
localparam logic [5:0] opc_bne     = 6'h05;
localparam logic [5:0] opc_addiu   = 6'h09;
localparam logic [5:0] opc_andi    = 6'h0c;
localparam logic [5:0] opc_ori     = 6'h0d;
localparam logic [5:0] opc_lw      = 6'h23;
localparam logic [5:0] opc_sw      = 6'h2b;
localparam logic [5:0] fnc_sll     = 6'h00;
localparam logic [5:0] fnc_addu    = 6'h21;
localparam logic [5:0] fnc_subu    = 6'h23;
localparam logic [5:0] fnc_and     = 6'h24;
localparam logic [5:0] fnc_or      = 6'h25;
localparam logic [5:0] fnc_slt     = 6'h2a;

logic [31:0] ref_imem [1024];
logic [31:0] ref_dmem [1024];
logic [31:0] ref_regs [32];
// word address in the top bits and data below
logic [41:0] exp_stores [$];

function automatic void clear_reference();
    foreach (ref_regs[i]) ref_regs[i] = '0;
    foreach (ref_dmem[i]) ref_dmem[i] = '0;
    foreach (ref_imem[i]) ref_imem[i] = '0;
    exp_stores.delete();
endfunction

// executes from address 0 up to a jump to itself and returns the instruction count
function automatic int run_reference(input int max_steps);
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] result;
    logic [31:0] addr;
    logic [4:0]  dest;
    logic        wr;
    pc = '0;
    for (int steps = 1; steps <= max_steps; steps++) begin
        instr = ref_imem[pc[11:2]];
        a = ref_regs[instr[25:21]];
        b = ref_regs[instr[20:16]];
        se = {{16{instr[15]}}, instr[15:0]};
        pc_plus4 = pc + 32'd4;
        addr = a + se;
        dest = instr[20:16];
        wr = 1'b1;
        result = '0;
        if (instr[31:26] == opc_j && {pc_plus4[31:28], instr[25:0], 2'b00} == pc) begin
            return steps;
        end
        case (instr[31:26])
            opc_special: begin
                dest = instr[15:11];
                case (instr[5:0])
                    fnc_addu: result = a + b;
                    fnc_subu: result = a - b;
                    fnc_and:  result = a & b;
                    fnc_or:   result = a | b;
                    fnc_slt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnc_sll:  result = b << instr[10:6];
                    default:  wr = 1'b0;
                endcase
            end
            opc_addiu: result = a + se;
            opc_andi:  result = a & {16'h0000, instr[15:0]};
            opc_ori:   result = a | {16'h0000, instr[15:0]};
            opc_lw:    result = ref_dmem[addr[11:2]];
            opc_sw: begin
                wr = 1'b0;
                ref_dmem[addr[11:2]] = b;
                exp_stores.push_back({addr[11:2], b});
            end
            opc_beq: begin
                wr = 1'b0;
                if (a == b) pc_plus4 = pc_plus4 + {se[29:0], 2'b00};
            end
            opc_bne: begin
                wr = 1'b0;
                if (a != b) pc_plus4 = pc_plus4 + {se[29:0], 2'b00};
            end
            opc_j: begin
                wr = 1'b0;
                pc_plus4 = {pc_plus4[31:28], instr[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) ref_regs[dest] = result;
        pc = pc_plus4;
    end
    return -1;
endfunction

`endif

/* test/mips_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_tb import mips_pkg::*; ();

    localparam int drain_cycles = 20;
    localparam int max_ref_steps = 4000;

    logic      clk;
    logic      reset;
    logic      run;
    logic      load_valid;
    load_req_t load;
    logic      load_ready;
    logic      store_valid;
    store_t    store;

    int          seed;
    int          cycle_count;
    int          cycle_limit;
    string       test_name;
    logic [31:0] prog [$];
    logic [41:0] preload [$];

    `include "mips_ref_model.svh"

    mips_top #(
        .imem_depth (1024),
        .dmem_depth (1024)
    ) i_mips_top (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .load_valid  (load_valid),
        .load        (load),
        .load_ready  (load_ready),
        .store_valid (store_valid),
        .store       (store)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [41:0] expected,
                               input logic [41:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout in %s after %0d cycles", test_name, cycle_count));
        end
    end

    // load port is ready exactly while the core is held
    always @(posedge clk) begin
        check_value(test_name, 42'(!run), 42'(load_ready));
    end

    // each store is compared in order against the reference
    always @(posedge clk) begin
        if (!reset && store_valid) begin
            if (exp_stores.size() == 0) begin
                abort_run($sformatf("unexpected store to word %h in %s", store.addr, test_name));
            end else begin
                check_value(test_name, exp_stores.pop_front(), {store.addr, store.data});
            end
        end
    end

    function automatic logic [31:0] r_type(logic [5:0] funct, int rd, int rs, int rt, int sh);
        return {opc_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] opcode, int rt, int rs, int imm);
        return {opcode, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jump_word(int index);
        return {opc_j, 26'(index)};
    endfunction

    // offset from the slot after the branch being added
    function automatic int branch_offset(int target);
        return target - (prog.size() + 1);
    endfunction

    task automatic add_halt();
        prog.push_back(jump_word(prog.size()));
    endtask

    task automatic write_word(input mem_target_t dest_mem, input logic [9:0] addr,
                              input logic [31:0] data);
        @(negedge clk);
        load_valid = 1'b1;
        load = '{target: dest_mem, addr: addr, data: data};
        do @(posedge clk); while (!load_ready);
    endtask

    task automatic run_program(input string name);
        int steps;
        test_name = name;
        foreach (prog[i]) ref_imem[i] = prog[i];
        foreach (preload[i]) ref_dmem[preload[i][41:32]] = preload[i][31:0];
        steps = run_reference(max_ref_steps);
        if (steps < 0) begin
            abort_run($sformatf("reference model never reached the halt loop in %s", name));
        end
        cycle_limit += prog.size() + preload.size() + 3 * steps + drain_cycles;
        foreach (preload[i]) write_word(target_dmem, preload[i][41:32], preload[i][31:0]);
        foreach (prog[i]) write_word(target_imem, 10'(i), prog[i]);
        @(negedge clk);
        load_valid = 1'b0;
        run = 1'b1;
        do @(negedge clk); while (exp_stores.size() != 0);
        // late or extra stores still show up in the monitor here
        repeat (drain_cycles) @(negedge clk);
        run = 1'b0;
        prog.delete();
        preload.delete();
    endtask

    task automatic preload_and_copy();
        preload.push_back({10'd16, 32'h1234_5678});
        preload.push_back({10'd17, 32'hcafe_0001});
        prog.push_back(i_type(opc_lw, 1, 0, 'h40));
        prog.push_back(i_type(opc_lw, 2, 0, 'h44));
        prog.push_back(i_type(opc_sw, 1, 0, 'h300));
        prog.push_back(i_type(opc_sw, 2, 0, 'h304));
        prog.push_back(i_type(opc_lw, 3, 0, 'h300));
        prog.push_back(i_type(opc_sw, 3, 0, 'h308));
        add_halt();
        run_program("preload and copy");
    endtask

    task automatic forwarding_chain();
        prog.push_back(i_type(opc_addiu, 1, 0, 5));
        prog.push_back(i_type(opc_addiu, 2, 1, 7));
        prog.push_back(i_type(opc_sw, 2, 0, 'h100));
        prog.push_back(r_type(fnc_addu, 3, 1, 2, 0));
        prog.push_back(i_type(opc_sw, 3, 0, 'h104));
        prog.push_back(r_type(fnc_subu, 4, 3, 1, 0));
        prog.push_back(i_type(opc_ori, 5, 4, 'hf0f0));
        prog.push_back(i_type(opc_sw, 4, 0, 'h108));
        prog.push_back(i_type(opc_sw, 5, 0, 'h10c));
        prog.push_back(i_type(opc_andi, 6, 5, 'h00ff));
        prog.push_back(r_type(fnc_sll, 7, 0, 6, 4));
        prog.push_back(i_type(opc_sw, 7, 0, 'h110));
        prog.push_back(i_type(opc_addiu, 10, 0, -3));
        prog.push_back(r_type(fnc_slt, 11, 10, 7, 0));
        prog.push_back(i_type(opc_sw, 11, 0, 'h114));
        prog.push_back(r_type(fnc_or, 12, 11, 7, 0));
        prog.push_back(r_type(fnc_and, 13, 12, 5, 0));
        prog.push_back(i_type(opc_sw, 13, 0, 'h118));
        add_halt();
        run_program("forwarding chain");
    endtask

    task automatic load_use_stall();
        preload.push_back({10'd32, 32'h0000_0010});
        prog.push_back(i_type(opc_lw, 1, 0, 'h80));
        prog.push_back(r_type(fnc_addu, 2, 1, 1, 0));
        prog.push_back(i_type(opc_sw, 2, 0, 'h140));
        prog.push_back(i_type(opc_lw, 3, 0, 'h80));
        prog.push_back(i_type(opc_sw, 3, 0, 'h144));
        prog.push_back(i_type(opc_lw, 4, 0, 'h80));
        prog.push_back(i_type(opc_addiu, 5, 4, 'h100));
        prog.push_back(i_type(opc_sw, 4, 5, 0));
        prog.push_back(i_type(opc_lw, 6, 0, 'h80));
        prog.push_back(i_type(opc_beq, 4, 6, 1));
        prog.push_back(i_type(opc_sw, 6, 0, 'h148));
        prog.push_back(i_type(opc_sw, 6, 0, 'h14c));
        add_halt();
        run_program("load use stall");
    endtask

    task automatic branch_paths();
        int loop_top;
        prog.push_back(i_type(opc_addiu, 1, 0, 3));
        prog.push_back(i_type(opc_addiu, 2, 0, 3));
        prog.push_back(i_type(opc_beq, 2, 1, 1));
        prog.push_back(i_type(opc_sw, 1, 0, 'h180));
        prog.push_back(i_type(opc_sw, 2, 0, 'h184));
        prog.push_back(i_type(opc_addiu, 3, 0, 4));
        prog.push_back(i_type(opc_bne, 3, 1, 1));
        prog.push_back(i_type(opc_sw, 3, 0, 'h188));
        prog.push_back(i_type(opc_addiu, 4, 1, 1));
        prog.push_back(i_type(opc_bne, 3, 4, 1));
        prog.push_back(i_type(opc_sw, 4, 0, 'h190));
        prog.push_back(i_type(opc_beq, 3, 1, 1));
        prog.push_back(i_type(opc_sw, 3, 0, 'h18c));
        // backward loop of three passes
        prog.push_back(i_type(opc_addiu, 5, 0, 3));
        loop_top = prog.size();
        prog.push_back(i_type(opc_addiu, 5, 5, -1));
        prog.push_back(i_type(opc_sw, 5, 0, 'h1a0));
        prog.push_back(i_type(opc_bne, 0, 5, branch_offset(loop_top)));
        add_halt();
        run_program("branch paths");
    endtask

    task automatic jump_skip();
        prog.push_back(i_type(opc_addiu, 1, 0, 'h55));
        prog.push_back(jump_word(4));
        prog.push_back(i_type(opc_sw, 1, 0, 'h1c0));
        prog.push_back(i_type(opc_sw, 1, 0, 'h1c4));
        prog.push_back(i_type(opc_sw, 1, 0, 'h1c8));
        prog.push_back(i_type(opc_addiu, 1, 1, 1));
        prog.push_back(i_type(opc_sw, 1, 0, 'h1cc));
        add_halt();
        run_program("jump skip");
    endtask

    task automatic random_alu_program();
        int kind;
        int rd;
        int rs;
        int rt;
        int imm;
        for (int r = 1; r < 8; r++) prog.push_back(i_type(opc_addiu, r, 0, $random(seed)));
        for (int n = 0; n < 48; n++) begin
            kind = int'($unsigned($random(seed)) % 32'd12);
            rd = 1 + int'($unsigned($random(seed)) % 32'd7);
            rs = int'($unsigned($random(seed)) % 32'd8);
            rt = int'($unsigned($random(seed)) % 32'd8);
            imm = $random(seed);
            case (kind)
                0: prog.push_back(r_type(fnc_addu, rd, rs, rt, 0));
                1: prog.push_back(r_type(fnc_subu, rd, rs, rt, 0));
                2: prog.push_back(r_type(fnc_and, rd, rs, rt, 0));
                3: prog.push_back(r_type(fnc_or, rd, rs, rt, 0));
                4: prog.push_back(r_type(fnc_slt, rd, rs, rt, 0));
                5: prog.push_back(r_type(fnc_sll, rd, 0, rt, imm & 31));
                6: prog.push_back(i_type(opc_addiu, rd, rs, imm));
                7: prog.push_back(i_type(opc_andi, rd, rs, imm));
                8: prog.push_back(i_type(opc_ori, rd, rs, imm));
                default: prog.push_back(i_type(opc_sw, rt, 0, 'h200 + 4 * (imm & 63)));
            endcase
        end
        add_halt();
        run_program("random alu program");
    endtask

    initial begin
        seed = 40847;
        clk = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        load_valid = 1'b0;
        load = '0;
        cycle_count = 0;
        cycle_limit = 16 + 200;
        test_name = "reset";
        clear_reference();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        preload_and_copy();
        forwarding_chain();
        load_use_stall();
        branch_paths();
        jump_skip();
        random_alu_program();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
